/* tb.f */
verilog/ucodePkg.sv
verilog/opcodeIntake.sv
verilog/flowDispatch.sv
verilog/microcodeRom.sv
verilog/flowSequencer.sv
verilog/uopIssue.sv
verilog/ucodeEngine.sv
dv/ucodeEngineProperties.sv
dv/ucodeEngineTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ucodeEngineTb
FILELIST = tb.f
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* dv/ucodeEngineTb.sv */
`timescale 1ns/1ps

module ucodeEngineTb;

	localparam int testCount = 6;
	localparam int cyclesPerTest = 200;

	// Expected length and final micro-op of one flow
	typedef struct packed
	{
		logic [7:0] code;
		logic [7:0] len;
		ucodePkg::seqAction action;
		ucodePkg::uopOperation operation;
		ucodePkg::uopOperand operand;
	} flowExp;

	logic clock;
	logic reset;
	logic opcodeValid;
	logic [ucodePkg::opcodeWidth-1:0] opcode;
	logic opcodeReady;
	logic zeroFlag;
	logic uopValid;
	ucodePkg::uopBeat uop;
	logic uopReady;

	int errorCount = 0;
	int checkCount = 0;
	int cycle = 0;
	int handshakeCycle;
	int firstUopCycle;
	integer seed = 32'hecaf_be06;
	logic [7:0] sendQ[$];
	flowExp expQ[$];

	ucodeEngine #(.addrWidth(ucodePkg::uopAddrWidth)) dut0
	(
		.clock(clock),
		.reset(reset),
		.opcodeValid(opcodeValid),
		.opcode(opcode),
		.opcodeReady(opcodeReady),
		.zeroFlag(zeroFlag),
		.uopValid(uopValid),
		.uop(uop),
		.uopReady(uopReady)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Edges seen so far
	always @(posedge clock)
		cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Drive point 1 ns past the edge
	task automatic tick;
		@(posedge clock);
		#1;
	endtask

	task automatic checkEqual(input int actual, input int expected, input string what);
		checkCount++;
		if (actual != expected)
		begin
			errorCount++;
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic queueFlow(input logic [7:0] code, input int len,
		input ucodePkg::seqAction action, input ucodePkg::uopOperation operation,
		input ucodePkg::uopOperand operand);
		flowExp f;
		f.code = code;
		f.len = 8'(len);
		f.action = action;
		f.operation = operation;
		f.operand = operand;
		sendQ.push_back(code);
		expQ.push_back(f);
	endtask

	// An early last shows up as a short flow
	task automatic checkFlow(input flowExp f, input ucodePkg::uopBeat got[$]);
		string name;
		int lastIdx;
		name = $sformatf("flow %02h", f.code);
		lastIdx = got.size() - 1;
		checkEqual(got.size(), int'(f.len), {name, " length"});
		checkEqual(int'(got[lastIdx].uop.action), int'(f.action), {name, " final action"});
		checkEqual(int'(got[lastIdx].uop.operation), int'(f.operation),
			{name, " final operation"});
		checkEqual(int'(got[lastIdx].uop.operand), int'(f.operand), {name, " final operand"});
	endtask

	task automatic sendBytes;
		while (sendQ.size() > 0)
		begin
			opcodeValid = 1'b1;
			opcode = sendQ[0];
			if (opcodeReady)
			begin
				if (handshakeCycle < 0)
					handshakeCycle = cycle + 1;
				void'(sendQ.pop_front());
			end
			tick();
		end
		opcodeValid = 1'b0;
	endtask

	task automatic collectFlows(input bit stalls);
		ucodePkg::uopBeat got[$];
		while (expQ.size() > 0)
		begin
			uopReady = stalls ? (($random(seed) & 3) != 0) : 1'b1;
			if (uopValid && firstUopCycle < 0)
				firstUopCycle = cycle;
			if (uopValid && uopReady)
			begin
				got.push_back(uop);
				if (uop.last)
				begin
					checkFlow(expQ.pop_front(), got);
					got.delete();
				end
			end
			tick();
		end
		uopReady = 1'b1;
	endtask

	task automatic runTraffic(input bit stalls);
		handshakeCycle = -1;
		firstUopCycle = -1;
		fork
			sendBytes();
			collectFlows(stalls);
		join
		if (!stalls)
			checkEqual(firstUopCycle - handshakeCycle, 3, "first micro-op latency");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic singleFlows;
		queueFlow(ucodePkg::opNop, 1, ucodePkg::incEof, ucodePkg::nop, ucodePkg::none);
		runTraffic(1'b0);
		queueFlow(ucodePkg::opIncB, 1, ucodePkg::incEofFlags, ucodePkg::inc16, ucodePkg::b);
		runTraffic(1'b0);
		queueFlow(ucodePkg::opIncC, 1, ucodePkg::incEofFlags, ucodePkg::inc16, ucodePkg::c);
		runTraffic(1'b0);
	endtask

	task automatic multiBeatFlows;
		queueFlow(ucodePkg::opLdBn, 3, ucodePkg::eof, ucodePkg::storeRegFromMem, ucodePkg::b);
		runTraffic(1'b0);
		queueFlow(ucodePkg::opLdCn, 3, ucodePkg::eof, ucodePkg::storeRegFromMem, ucodePkg::c);
		runTraffic(1'b0);
		queueFlow(ucodePkg::opAddAB, 3, ucodePkg::incEof, ucodePkg::setRegFromX16, ucodePkg::a);
		runTraffic(1'b0);
		queueFlow(ucodePkg::opPushBc, 6, ucodePkg::incEof, ucodePkg::setMemAddr, ucodePkg::pc);
		runTraffic(1'b0);
	endtask

	// Short flow ends on the conditional micro-op, long one on setPc
	task automatic conditionalEnd;
		zeroFlag = 1'b1;
		queueFlow(ucodePkg::opJrNz, 3, ucodePkg::incEofZ, ucodePkg::storeRegFromMem, ucodePkg::x8);
		queueFlow(ucodePkg::opJrZ, 6, ucodePkg::eof, ucodePkg::setPc, ucodePkg::x16);
		runTraffic(1'b0);
		zeroFlag = 1'b0;
		queueFlow(ucodePkg::opJrNz, 6, ucodePkg::eof, ucodePkg::setPc, ucodePkg::x16);
		queueFlow(ucodePkg::opJrZ, 3, ucodePkg::incEofNz, ucodePkg::storeRegFromMem, ucodePkg::x8);
		runTraffic(1'b0);
	endtask

	task automatic cbPrefix;
		sendQ.push_back(ucodePkg::opPrefixCb);
		queueFlow(ucodePkg::cbBit7H, 4, ucodePkg::eofFlags, ucodePkg::bitTest, ucodePkg::h);
		runTraffic(1'b0);
		sendQ.push_back(ucodePkg::opPrefixCb);
		queueFlow(ucodePkg::cbRlB, 4, ucodePkg::eofFlags, ucodePkg::shiftLeft, ucodePkg::b);
		runTraffic(1'b0);
	endtask

	task automatic unknownOpcodes;
		queueFlow(8'h3e, 2, ucodePkg::incEof, ucodePkg::nop, ucodePkg::none);
		runTraffic(1'b0);
		queueFlow(8'hff, 2, ucodePkg::incEof, ucodePkg::nop, ucodePkg::none);
		runTraffic(1'b0);
		// Unknown CB byte ends after one step
		sendQ.push_back(ucodePkg::opPrefixCb);
		queueFlow(8'h00, 4, ucodePkg::incEof, ucodePkg::nop, ucodePkg::none);
		runTraffic(1'b0);
	endtask

	task automatic mixedStream;
		queueFlow(ucodePkg::opNop, 1, ucodePkg::incEof, ucodePkg::nop, ucodePkg::none);
		queueFlow(ucodePkg::opLdBn, 3, ucodePkg::eof, ucodePkg::storeRegFromMem, ucodePkg::b);
		queueFlow(ucodePkg::opPushBc, 6, ucodePkg::incEof, ucodePkg::setMemAddr, ucodePkg::pc);
		queueFlow(ucodePkg::opJrNz, 6, ucodePkg::eof, ucodePkg::setPc, ucodePkg::x16);
		sendQ.push_back(ucodePkg::opPrefixCb);
		queueFlow(ucodePkg::cbBit7H, 4, ucodePkg::eofFlags, ucodePkg::bitTest, ucodePkg::h);
		queueFlow(ucodePkg::opAddAB, 3, ucodePkg::incEof, ucodePkg::setRegFromX16, ucodePkg::a);
		queueFlow(ucodePkg::opJrZ, 3, ucodePkg::incEofNz, ucodePkg::storeRegFromMem, ucodePkg::x8);
		queueFlow(8'h3e, 2, ucodePkg::incEof, ucodePkg::nop, ucodePkg::none);
		sendQ.push_back(ucodePkg::opPrefixCb);
		queueFlow(ucodePkg::cbRlB, 4, ucodePkg::eofFlags, ucodePkg::shiftLeft, ucodePkg::b);
		queueFlow(ucodePkg::opIncC, 1, ucodePkg::incEofFlags, ucodePkg::inc16, ucodePkg::c);
	endtask

	task automatic backPressure;
		zeroFlag = 1'b0;
		mixedStream();
		runTraffic(1'b1);
		mixedStream();
		runTraffic(1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		opcodeValid = 1'b0;
		opcode = '0;
		zeroFlag = 1'b0;
		uopReady = 1'b1;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		singleFlows();
		multiBeatFlows();
		conditionalEnd();
		cbPrefix();
		unknownOpcodes();
		backPressure();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		repeat (10 + testCount * cyclesPerTest) @(posedge clock);
		$display("Timeout: the tests did not finish within %0d cycles",
			testCount * cyclesPerTest);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* dv/ucodeEngineProperties.sv */
`timescale 1ns/1ps

module ucodeEngineProperties
(
	input logic clock,
	input logic reset,
	input logic opcodeReady,
	input logic uopValid,
	input logic uopReady,
	input ucodePkg::uopBeat uop
);

	// Output slice comes up empty
	property validLowAfterReset;
		@(posedge clock) reset |=> !uopValid;
	endproperty

	// Micro-op stays put while the consumer stalls
	property uopHeldUnderStall;
		@(posedge clock) disable iff (reset)
		uopValid && !uopReady |=> uopValid && $stable(uop);
	endproperty

	// Intake is closed from the second reset edge on
	property noIntakeInReset;
		@(posedge clock) reset && $past(reset) |-> !opcodeReady;
	endproperty

	assert property (validLowAfterReset)
		else $error("uopValid high in the cycle after reset");
	assert property (uopHeldUnderStall)
		else $error("uop changed or dropped while stalled");
	assert property (noIntakeInReset)
		else $error("opcodeReady high during reset");

endmodule

bind ucodeEngine ucodeEngineProperties props0
(
	.clock(clock),
	.reset(reset),
	.opcodeReady(opcodeReady),
	.uopValid(uopValid),
	.uopReady(uopReady),
	.uop(uop)
);

/* verilog/ucodeEngine.sv */
`timescale 1ns/1ps

module ucodeEngine
#(
	parameter int addrWidth = ucodePkg::uopAddrWidth
)
(
	input  logic clock,
	input  logic reset,
	input  logic opcodeValid,
	input  logic [ucodePkg::opcodeWidth-1:0] opcode,
	output logic opcodeReady,
	input  logic zeroFlag,
	output logic uopValid,
	output ucodePkg::uopBeat uop,
	input  logic uopReady
);

	logic heldValid;
	logic heldReady;
	logic [ucodePkg::opcodeWidth-1:0] heldOpcode;
	logic [ucodePkg::opcodeWidth-1:0] dispatchOpcode;
	logic useCbTable;
	logic [addrWidth-1:0] startAddr;
	logic [addrWidth-1:0] romAddr;
	ucodePkg::microOp romUop;
	logic beatValid;
	logic beatReady;
	ucodePkg::uopBeat beat;

	////////////////////////////////////////////////////////////////////////////
	// Opcode in, micro-ops out
	////////////////////////////////////////////////////////////////////////////

	opcodeIntake intake0
	(
		.clock(clock),
		.reset(reset),
		.opcodeValid(opcodeValid),
		.opcode(opcode),
		.opcodeReady(opcodeReady),
		.heldValid(heldValid),
		.heldOpcode(heldOpcode),
		.heldReady(heldReady)
	);

	flowDispatch #(.addrWidth(addrWidth)) dispatch0
	(
		.dispatchOpcode(dispatchOpcode),
		.useCbTable(useCbTable),
		.startAddr(startAddr)
	);

	microcodeRom #(.addrWidth(addrWidth)) rom0
	(
		.romAddr(romAddr),
		.romUop(romUop)
	);

	flowSequencer #(.addrWidth(addrWidth)) sequencer0
	(
		.clock(clock),
		.reset(reset),
		.heldValid(heldValid),
		.heldOpcode(heldOpcode),
		.heldReady(heldReady),
		.zeroFlag(zeroFlag),
		.dispatchOpcode(dispatchOpcode),
		.useCbTable(useCbTable),
		.startAddr(startAddr),
		.romAddr(romAddr),
		.romUop(romUop),
		.beatValid(beatValid),
		.beat(beat),
		.beatReady(beatReady)
	);

	uopIssue issue0
	(
		.clock(clock),
		.reset(reset),
		.beatValid(beatValid),
		.beat(beat),
		.beatReady(beatReady),
		.uopValid(uopValid),
		.uop(uop),
		.uopReady(uopReady)
	);

endmodule

/* verilog/uopIssue.sv */
`timescale 1ns/1ps

module uopIssue
(
	input  logic clock,
	input  logic reset,
	input  logic beatValid,
	input  ucodePkg::uopBeat beat,
	output logic beatReady,
	output logic uopValid,
	output ucodePkg::uopBeat uop,
	input  logic uopReady
);

	logic load;

	// Take a new beat when the slot is empty or drains this cycle
	assign beatReady = !uopValid || uopReady;
	assign load = beatValid && beatReady;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			uopValid <= 1'b0;
		end
		else
		begin
			if (load)
				uopValid <= 1'b1;
			else if (uopReady)
				uopValid <= 1'b0;
		end
	end

	// Held steady while the consumer stalls
	always_ff @(posedge clock)
	begin
		if (load)
			uop <= beat;
	end

endmodule

/* verilog/flowSequencer.sv */
`timescale 1ns/1ps

module flowSequencer
#(
	parameter int addrWidth = ucodePkg::uopAddrWidth
)
(
	input  logic clock,
	input  logic reset,
	input  logic heldValid,
	input  logic [ucodePkg::opcodeWidth-1:0] heldOpcode,
	output logic heldReady,
	input  logic zeroFlag,
	output logic [ucodePkg::opcodeWidth-1:0] dispatchOpcode,
	output logic useCbTable,
	input  logic [addrWidth-1:0] startAddr,
	output logic [addrWidth-1:0] romAddr,
	input  ucodePkg::microOp romUop,
	output logic beatValid,
	output ucodePkg::uopBeat beat,
	input  logic beatReady
);

	ucodePkg::seqState state;
	logic [addrWidth-1:0] uPc;
	logic flowEnd;
	logic beatFire;

	////////////////////////////////////////////////////////////////////////////
	// End of flow
	////////////////////////////////////////////////////////////////////////////

	// Conditional ends look at the zero flag in the issuing cycle
	always_comb
	begin
		case (romUop.action)
			ucodePkg::eof,
			ucodePkg::incEof,
			ucodePkg::incEofFlags,
			ucodePkg::eofFlags: flowEnd = 1'b1;
			ucodePkg::incEofZ:  flowEnd = zeroFlag;
			ucodePkg::incEofNz: flowEnd = !zeroFlag;
			default:            flowEnd = 1'b0;
		endcase
	end

	assign heldReady = (state == ucodePkg::idle) || (state == ucodePkg::waitCbByte);
	assign beatValid = (state == ucodePkg::run);
	assign beatFire = beatValid && beatReady;
	assign romAddr = uPc;

	// Beat comes straight off the ROM, so a stall holds it with uPc
	always_comb
	begin
		beat.uop = romUop;
		beat.last = flowEnd;
	end

	////////////////////////////////////////////////////////////////////////////
	// FSM and micro-program counter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= ucodePkg::idle;
			uPc <= '0;
			useCbTable <= 1'b0;
		end
		else
		begin
			case (state)
				ucodePkg::idle,
				ucodePkg::waitCbByte:
					if (heldValid)
					begin
						// Second byte of a CB pair goes through the CB table
						useCbTable <= (state == ucodePkg::waitCbByte);
						state <= ucodePkg::fetchStart;
					end
				ucodePkg::fetchStart:
				begin
					uPc <= startAddr;
					state <= ucodePkg::run;
				end
				ucodePkg::run:
					if (beatFire)
					begin
						if (flowEnd)
							state <= ucodePkg::idle;
						else if (romUop.action == ucodePkg::jumpCb)
							state <= ucodePkg::waitCbByte;
						else
							uPc <= uPc + 1'b1;
					end
				default:
					state <= ucodePkg::idle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (heldValid && heldReady)
			dispatchOpcode <= heldOpcode;
	end

endmodule

/* verilog/microcodeRom.sv */
`timescale 1ns/1ps

module microcodeRom
#(
	parameter int addrWidth = ucodePkg::uopAddrWidth
)
(
	input  logic [addrWidth-1:0] romAddr,
	output ucodePkg::microOp romUop
);

	always_comb
	begin
		case (int'(romAddr))
			// NOP
			0:  romUop = '{ucodePkg::incEof, ucodePkg::nop, ucodePkg::none};

			// LD B,n
			1:  romUop = '{ucodePkg::inc, ucodePkg::setMemAddr, ucodePkg::pc};
			2:  romUop = '{ucodePkg::inc, ucodePkg::nop, ucodePkg::none};
			3:  romUop = '{ucodePkg::eof, ucodePkg::storeRegFromMem, ucodePkg::b};

			// LD C,n
			4:  romUop = '{ucodePkg::inc, ucodePkg::setMemAddr, ucodePkg::pc};
			5:  romUop = '{ucodePkg::inc, ucodePkg::nop, ucodePkg::none};
			6:  romUop = '{ucodePkg::eof, ucodePkg::storeRegFromMem, ucodePkg::c};

			// INC B, INC C
			7:  romUop = '{ucodePkg::incEofFlags, ucodePkg::inc16, ucodePkg::b};
			8:  romUop = '{ucodePkg::incEofFlags, ucodePkg::inc16, ucodePkg::c};

			// ADD A,B through x16
			9:  romUop = '{ucodePkg::op, ucodePkg::setX16FromReg, ucodePkg::a};
			10: romUop = '{ucodePkg::updateFlags, ucodePkg::addX16, ucodePkg::b};
			11: romUop = '{ucodePkg::incEof, ucodePkg::setRegFromX16, ucodePkg::a};

			// PUSH BC, high byte first
			12: romUop = '{ucodePkg::op, ucodePkg::dec16, ucodePkg::sp};
			13: romUop = '{ucodePkg::op, ucodePkg::setMemAddr, ucodePkg::sp};
			14: romUop = '{ucodePkg::op, ucodePkg::storeMemFromReg, ucodePkg::b};
			15: romUop = '{ucodePkg::op, ucodePkg::dec16, ucodePkg::sp};
			16: romUop = '{ucodePkg::op, ucodePkg::storeMemFromReg, ucodePkg::c};
			17: romUop = '{ucodePkg::incEof, ucodePkg::setMemAddr, ucodePkg::pc};

			// JR NZ,n
			18: romUop = '{ucodePkg::inc, ucodePkg::setMemAddr, ucodePkg::pc};
			19: romUop = '{ucodePkg::op, ucodePkg::nop, ucodePkg::none};
			// Z set means not taken, else x8 gets the offset
			20: romUop = '{ucodePkg::incEofZ, ucodePkg::storeRegFromMem, ucodePkg::x8};
			21: romUop = '{ucodePkg::op, ucodePkg::setX16FromReg, ucodePkg::pc};
			22: romUop = '{ucodePkg::op, ucodePkg::addX16, ucodePkg::x8};
			23: romUop = '{ucodePkg::eof, ucodePkg::setPc, ucodePkg::x16};

			// JR Z,n
			24: romUop = '{ucodePkg::inc, ucodePkg::setMemAddr, ucodePkg::pc};
			25: romUop = '{ucodePkg::op, ucodePkg::nop, ucodePkg::none};
			26: romUop = '{ucodePkg::incEofNz, ucodePkg::storeRegFromMem, ucodePkg::x8};
			27: romUop = '{ucodePkg::op, ucodePkg::setX16FromReg, ucodePkg::pc};
			28: romUop = '{ucodePkg::op, ucodePkg::addX16, ucodePkg::x8};
			29: romUop = '{ucodePkg::eof, ucodePkg::setPc, ucodePkg::x16};

			// CB prefix, then redispatch on the next byte
			30: romUop = '{ucodePkg::inc, ucodePkg::setMemAddr, ucodePkg::pc};
			31: romUop = '{ucodePkg::op, ucodePkg::nop, ucodePkg::none};
			32: romUop = '{ucodePkg::jumpCb, ucodePkg::prefixCb, ucodePkg::none};

			// BIT 7,H and RL B
			33: romUop = '{ucodePkg::eofFlags, ucodePkg::bitTest, ucodePkg::h};
			34: romUop = '{ucodePkg::eofFlags, ucodePkg::shiftLeft, ucodePkg::b};

			// Fall-back for opcodes with no flow
			35: romUop = '{ucodePkg::updateFlags, ucodePkg::nop, ucodePkg::none};
			36: romUop = '{ucodePkg::incEof, ucodePkg::nop, ucodePkg::none};

			default:
				romUop = '{ucodePkg::op, ucodePkg::nop, ucodePkg::none};
		endcase
	end

endmodule

/* verilog/flowDispatch.sv */
`timescale 1ns/1ps

module flowDispatch
#(
	parameter int addrWidth = ucodePkg::uopAddrWidth
)
(
	input  logic [ucodePkg::opcodeWidth-1:0] dispatchOpcode,
	input  logic useCbTable,
	output logic [addrWidth-1:0] startAddr
);

	// Flow entry points in the microcode ROM
	localparam logic [addrWidth-1:0] flowNop = addrWidth'(0);
	localparam logic [addrWidth-1:0] flowLdBn = addrWidth'(1);
	localparam logic [addrWidth-1:0] flowLdCn = addrWidth'(4);
	localparam logic [addrWidth-1:0] flowIncB = addrWidth'(7);
	localparam logic [addrWidth-1:0] flowIncC = addrWidth'(8);
	localparam logic [addrWidth-1:0] flowAddAB = addrWidth'(9);
	localparam logic [addrWidth-1:0] flowPushBc = addrWidth'(12);
	localparam logic [addrWidth-1:0] flowJrNz = addrWidth'(18);
	localparam logic [addrWidth-1:0] flowJrZ = addrWidth'(24);
	localparam logic [addrWidth-1:0] flowPrefixCb = addrWidth'(30);
	localparam logic [addrWidth-1:0] flowBit7H = addrWidth'(33);
	localparam logic [addrWidth-1:0] flowRlB = addrWidth'(34);
	localparam logic [addrWidth-1:0] flowUnknown = addrWidth'(35);

	logic [addrWidth-1:0] mainAddr;
	logic [addrWidth-1:0] cbAddr;

	////////////////////////////////////////////////////////////////////////////
	// Main table
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (dispatchOpcode)
			ucodePkg::opNop:      mainAddr = flowNop;
			ucodePkg::opLdBn:     mainAddr = flowLdBn;
			ucodePkg::opLdCn:     mainAddr = flowLdCn;
			ucodePkg::opIncB:     mainAddr = flowIncB;
			ucodePkg::opIncC:     mainAddr = flowIncC;
			ucodePkg::opAddAB:    mainAddr = flowAddAB;
			ucodePkg::opPushBc:   mainAddr = flowPushBc;
			ucodePkg::opJrNz:     mainAddr = flowJrNz;
			ucodePkg::opJrZ:      mainAddr = flowJrZ;
			ucodePkg::opPrefixCb: mainAddr = flowPrefixCb;
			default:              mainAddr = flowUnknown;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// CB table
	////////////////////////////////////////////////////////////////////////////

	// Unknown CB bytes run the one-beat NOP flow
	always_comb
	begin
		case (dispatchOpcode)
			ucodePkg::cbBit7H: cbAddr = flowBit7H;
			ucodePkg::cbRlB:   cbAddr = flowRlB;
			default:           cbAddr = flowNop;
		endcase
	end

	assign startAddr = useCbTable ? cbAddr : mainAddr;

endmodule

/* verilog/opcodeIntake.sv */
`timescale 1ns/1ps

module opcodeIntake
(
	input  logic clock,
	input  logic reset,
	input  logic opcodeValid,
	input  logic [ucodePkg::opcodeWidth-1:0] opcode,
	output logic opcodeReady,
	output logic heldValid,
	output logic [ucodePkg::opcodeWidth-1:0] heldOpcode,
	input  logic heldReady
);

	// Low through reset, high from the first cycle after it
	logic intakeLive;
	logic accept;

	// Slot empty, or emptied by the sequencer this cycle
	assign opcodeReady = intakeLive && (!heldValid || heldReady);
	assign accept = opcodeValid && opcodeReady;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			intakeLive <= 1'b0;
			heldValid <= 1'b0;
		end
		else
		begin
			intakeLive <= 1'b1;
			if (accept)
				heldValid <= 1'b1;
			else if (heldReady)
				heldValid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			heldOpcode <= opcode;
	end

endmodule

/* verilog/ucodePkg.sv */
package ucodePkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int opcodeWidth = 8;
	localparam int uopAddrWidth = 6;

	////////////////////////////////////////////////////////////////////////////
	// Micro-op fields
	////////////////////////////////////////////////////////////////////////////

	// What the sequencer does after the micro-op
	typedef enum logic [3:0]
	{
		op,
		inc,
		eof,
		incEof,
		incEofFlags,
		eofFlags,
		updateFlags,
		incEofZ,
		incEofNz,
		jumpCb
	} seqAction;

	// Datapath operation
	typedef enum logic [4:0]
	{
		nop,
		setMemAddr,
		storeRegFromMem,
		storeMemFromReg,
		inc16,
		dec16,
		addX16,
		subX16,
		setX16FromReg,
		setRegFromX16,
		setPc,
		bitTest,
		shiftLeft,
		prefixCb
	} uopOperation;

	// Register selector
	typedef enum logic [4:0]
	{
		none, a, b, c, d, e, h, l, sp, pc, pch, hl, bc, x8, x16
	} uopOperand;

	typedef struct packed
	{
		seqAction action;
		uopOperation operation;
		uopOperand operand;
	} microOp;

	// One beat on the issue stream, last marks the end of a flow
	typedef struct packed
	{
		microOp uop;
		logic last;
	} uopBeat;

	typedef enum logic [1:0]
	{
		idle,
		fetchStart,
		run,
		waitCbByte
	} seqState;

	////////////////////////////////////////////////////////////////////////////
	// Opcode bytes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [opcodeWidth-1:0] opNop = 8'h00;
	localparam logic [opcodeWidth-1:0] opIncB = 8'h04;
	localparam logic [opcodeWidth-1:0] opLdBn = 8'h06;
	localparam logic [opcodeWidth-1:0] opIncC = 8'h0c;
	localparam logic [opcodeWidth-1:0] opLdCn = 8'h0e;
	localparam logic [opcodeWidth-1:0] opJrNz = 8'h20;
	localparam logic [opcodeWidth-1:0] opJrZ = 8'h28;
	localparam logic [opcodeWidth-1:0] opAddAB = 8'h80;
	localparam logic [opcodeWidth-1:0] opPushBc = 8'hc5;
	localparam logic [opcodeWidth-1:0] opPrefixCb = 8'hcb;

	// Second byte after the CB prefix
	localparam logic [opcodeWidth-1:0] cbRlB = 8'h10;
	localparam logic [opcodeWidth-1:0] cbBit7H = 8'h7c;

endpackage
